/* replay_top.f */
+incdir+.
replay_pkg.sv
beat_if.sv
ingress_fifo.sv
fifo_to_mem.sv
word_ram.sv
mem_to_fifo.sv
replay_top.sv
tb_replay.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_replay
FILELIST  = replay_top.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

/* tb_replay.sv */
`timescale 1ns/10ps
`default_nettype none

`include "replay_settings.svh"

module tb_replay import replay_pkg::*; ();

  localparam int N_SINGLE   = 20;
  localparam int N_MIX      = 60;
  localparam int FILL_PKTS  = 9;
  localparam int MAX_BEATS  = 8 * N_SINGLE + 8 * FILL_PKTS + 8 * N_MIX;
  localparam int RING_WORDS = 1 << `REPLAY_SLOT_W;
  localparam int DRAIN_MAX  = 2000;
  localparam qid_t FILL_Q   = 2'd2;

  logic        clk;
  logic        rst;
  word_t       in_data;
  qid_t        in_qid;
  logic        in_last;
  logic        in_valid;
  logic        in_ready;
  word_t       out_data;
  qid_t        out_qid;
  logic        out_valid;
  logic        out_ready;
  logic [15:0] drop_count;

  integer seed;
  bit     rand_ready;
  bit     rand_gaps;
  string  cur_test;
  int     errors;
  int     test_start_errors;
  int     n_pass;
  int     n_fail;
  int     model_drops;
  int     base_count;
  int     wait_n;
  int     idle_hits;
  qid_t   q;
  bit     admit;
  word_t  mon_exp;
  // Expected words per queue in replay order
  word_t  exp_q [`REPLAY_NUM_Q][$];
  int     adm_cnt [`REPLAY_NUM_Q];
  int     rcv_cnt [`REPLAY_NUM_Q];

  replay_top replay_top_i (
    .clk        (clk),
    .rst        (rst),
    .in_data    (in_data),
    .in_qid     (in_qid),
    .in_last    (in_last),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_data   (out_data),
    .out_qid    (out_qid),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .drop_count (drop_count)
  );

  always #20 clk = ~clk;

  // One clock step with inputs changing 2 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
    if (rand_ready) begin
      out_ready = 1'($random(seed));
    end
  endtask

  // A queue takes a new packet while its free space covers a full packet
  function automatic bit room(input qid_t rq);
    return (RING_WORDS - exp_q[rq].size()) >= `REPLAY_MAX_PKT;
  endfunction

  function automatic int pending_words();
    int sum;
    sum = 0;
    for (int i = 0; i < `REPLAY_NUM_Q; i++) begin
      sum += exp_q[i].size();
    end
    return sum;
  endfunction

  task automatic send_packet(input qid_t pq, input int len, input bit keep);
    word_t w;
    for (int i = 0; i < len; i++) begin
      w        = $random(seed);
      in_data  = w;
      in_qid   = pq;
      in_last  = (i == len - 1);
      in_valid = 1'b1;
      if (keep) begin
        exp_q[pq].push_back(w);
        adm_cnt[pq]++;
      end
      // in_ready only changes on a clock edge
      @(negedge clk);
      while (!in_ready) begin
        next_cycle();
        @(negedge clk);
      end
      next_cycle();
      in_valid = 1'b0;
      if (rand_gaps) begin
        repeat ($unsigned($random(seed)) % 3) next_cycle();
      end
    end
  endtask

  // Skips a cycle when the model cannot be sure of admission
  task automatic send_if_room(input qid_t pq, input int len);
    if (room(pq)) begin
      send_packet(pq, len, 1'b1);
    end else begin
      next_cycle();
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending_words() != 0 && n < DRAIN_MAX) begin
      next_cycle();
      n++;
    end
    if (pending_words() != 0) begin
      errors++;
      $display("%s: output stalled with %0d expected words never replayed",
               cur_test, pending_words());
    end
  endtask

  task automatic check_counts();
    for (int i = 0; i < `REPLAY_NUM_Q; i++) begin
      if (rcv_cnt[i] != adm_cnt[i]) begin
        errors++;
        $display("CHECK FAILED %s: queue %0d word count expected %0d actual %0d",
                 cur_test, i, adm_cnt[i], rcv_cnt[i]);
      end
    end
  endtask

  task automatic start_test(input string name);
    cur_test          = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    if (errors == test_start_errors) begin
      n_pass++;
      $display("test %s: ok", cur_test);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", cur_test, errors - test_start_errors);
    end
  endtask

  // Output monitor sampled mid-cycle where the handshake is stable
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (exp_q[out_qid].size() == 0) begin
        errors++;
        $display("%s: unexpected word %h replayed on queue %0d", cur_test, out_data, out_qid);
      end else begin
        mon_exp = exp_q[out_qid].pop_front();
        rcv_cnt[out_qid]++;
        if (out_data != mon_exp) begin
          errors++;
          $display("CHECK FAILED %s: queue %0d data expected %h actual %h",
                   cur_test, out_qid, mon_exp, out_data);
        end
      end
    end
  end

  initial begin
    repeat (MAX_BEATS * 20) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not complete", MAX_BEATS * 20);
    $display("sim failed");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    in_data     = '0;
    in_qid      = '0;
    in_last     = 1'b0;
    in_valid    = 1'b0;
    out_ready   = 1'b0;
    seed        = 32'hd2b159a2;
    rand_ready  = 1'b0;
    rand_gaps   = 1'b0;
    errors      = 0;
    n_pass      = 0;
    n_fail      = 0;
    model_drops = 0;
    for (int i = 0; i < `REPLAY_NUM_Q; i++) begin
      adm_cnt[i] = 0;
      rcv_cnt[i] = 0;
    end
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    start_test("reset");
    if (out_valid !== 1'b0) begin
      errors++;
      $display("CHECK FAILED %s: out_valid expected 0 actual %b", cur_test, out_valid);
    end
    if (drop_count !== 16'd0) begin
      errors++;
      $display("CHECK FAILED %s: drop_count expected 0 actual %0d", cur_test, drop_count);
    end
    wait_n = 0;
    @(negedge clk);
    while (!in_ready && wait_n < 2) begin
      next_cycle();
      @(negedge clk);
      wait_n++;
    end
    if (!in_ready) begin
      errors++;
      $display("%s: in_ready still low two cycles after reset", cur_test);
    end
    next_cycle();
    end_test();

    start_test("single_packets");
    out_ready = 1'b1;
    for (int i = 0; i < N_SINGLE; i++) begin
      q = qid_t'($random(seed));
      send_if_room(q, $unsigned($random(seed)) % 8 + 1);
    end
    wait_drain();
    check_counts();
    end_test();

    // Heads stay frozen so the model occupancy is exact
    start_test("fill_and_drop");
    out_ready = 1'b0;
    for (int p = 0; p < FILL_PKTS; p++) begin
      admit = room(FILL_Q);
      send_packet(FILL_Q, 8, admit);
      // Earlier packets have all passed the four-entry FIFO by now
      if (drop_count != 16'(model_drops)) begin
        errors++;
        $display("CHECK FAILED %s: drop_count after packet %0d expected %0d actual %0d",
                 cur_test, p, model_drops, drop_count);
      end
      if (!admit) begin
        model_drops++;
      end
    end
    wait_n = 0;
    while (drop_count != 16'(model_drops) && wait_n < 40) begin
      next_cycle();
      wait_n++;
    end
    if (drop_count != 16'(model_drops)) begin
      errors++;
      $display("CHECK FAILED %s: drop_count expected %0d actual %0d",
               cur_test, model_drops, drop_count);
    end
    end_test();

    start_test("drain_after_fill");
    base_count = rcv_cnt[FILL_Q];
    out_ready  = 1'b1;
    wait_drain();
    if (rcv_cnt[FILL_Q] - base_count != 8 * 8) begin
      errors++;
      $display("CHECK FAILED %s: words replayed expected %0d actual %0d",
               cur_test, 8 * 8, rcv_cnt[FILL_Q] - base_count);
    end
    idle_hits = 0;
    repeat (16) begin
      @(negedge clk);
      if (out_valid) begin
        idle_hits++;
      end
    end
    if (idle_hits != 0) begin
      errors++;
      $display("CHECK FAILED %s: cycles with out_valid after drain expected 0 actual %0d",
               cur_test, idle_hits);
    end
    check_counts();
    end_test();

    start_test("random_mix");
    rand_ready = 1'b1;
    rand_gaps  = 1'b1;
    next_cycle();
    for (int i = 0; i < N_MIX; i++) begin
      q = qid_t'($random(seed));
      send_if_room(q, $unsigned($random(seed)) % 8 + 1);
    end
    rand_ready = 1'b0;
    rand_gaps  = 1'b0;
    out_ready  = 1'b1;
    wait_drain();
    check_counts();
    if (drop_count != 16'(model_drops)) begin
      errors++;
      $display("CHECK FAILED %s: drop_count expected %0d actual %0d",
               cur_test, model_drops, drop_count);
    end
    end_test();

    $display("tests ok %0d, tests with errors %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* replay_top.sv */
`timescale 1ns/10ps
`default_nettype none

module replay_top import replay_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  word_t       in_data,
  input  qid_t        in_qid,
  input  logic        in_last,
  input  logic        in_valid,
  output logic        in_ready,
  output word_t       out_data,
  output qid_t        out_qid,
  output logic        out_valid,
  input  logic        out_ready,
  output logic [15:0] drop_count
);

  qptr_arr_t heads;
  qptr_arr_t tails;
  logic      wr_en;
  mem_addr_t wr_addr;
  word_t     wr_data;
  logic      rd_en;
  mem_addr_t rd_addr;
  word_t     rd_data;

  // Beats from the ingress FIFO to the writer
  beat_if beats ();

  ingress_fifo ingress_fifo_i (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .in_qid   (in_qid),
    .in_last  (in_last),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .beats    (beats)
  );

  fifo_to_mem fifo_to_mem_i (
    .clk        (clk),
    .rst        (rst),
    .beats      (beats),
    .heads      (heads),
    .tails      (tails),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .drop_count (drop_count)
  );

  word_ram word_ram_i (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  mem_to_fifo mem_to_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .tails     (tails),
    .heads     (heads),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .out_data  (out_data),
    .out_qid   (out_qid),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

/* mem_to_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "replay_settings.svh"

module mem_to_fifo import replay_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  qptr_arr_t tails,
  output qptr_arr_t heads,
  output logic      rd_en,
  output mem_addr_t rd_addr,
  input  word_t     rd_data,
  output word_t     out_data,
  output qid_t      out_qid,
  output logic      out_valid,
  input  logic      out_ready
);

  rd_state_e state;
  // Queue being served, or the last one served while picking
  qid_t      cur_q;
  qid_t      pick_q;
  logic      pick_found;

  // Round robin search starting after the last queue served
  always_comb begin
    pick_found = 1'b0;
    pick_q     = cur_q;
    for (int i = 1; i <= `REPLAY_NUM_Q; i++) begin
      if (!pick_found && tails[qid_t'(cur_q + i)] != heads[qid_t'(cur_q + i)]) begin
        pick_found = 1'b1;
        pick_q     = qid_t'(cur_q + i);
      end
    end
  end

  assign rd_en   = (state == RD_PICK) && pick_found;
  assign rd_addr = {pick_q, heads[pick_q][`REPLAY_SLOT_W-1:0]};

  assign out_valid = (state == RD_SEND);
  assign out_qid   = cur_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RD_PICK;
      // First search then begins at queue 0
      cur_q <= qid_t'(`REPLAY_NUM_Q - 1);
      heads <= '0;
    end else begin
      case (state)
        RD_PICK: begin
          if (pick_found) begin
            cur_q <= pick_q;
            state <= RD_FETCH;
          end
        end
        RD_FETCH: begin
          state <= RD_SEND;
        end
        RD_SEND: begin
          // Head moves only once the word is taken
          if (out_ready) begin
            heads[cur_q] <= heads[cur_q] + 1'b1;
            state        <= RD_PICK;
          end
        end
        default: begin
          state <= RD_PICK;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == RD_FETCH) begin
      out_data <= rd_data;
    end
  end

endmodule

`default_nettype wire

/* word_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module word_ram import replay_pkg::*; (
  input  logic      clk,
  input  logic      wr_en,
  input  mem_addr_t wr_addr,
  input  word_t     wr_data,
  input  logic      rd_en,
  input  mem_addr_t rd_addr,
  output word_t     rd_data
);

  localparam int DEPTH = 1 << $bits(mem_addr_t);

  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* fifo_to_mem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "replay_settings.svh"

module fifo_to_mem import replay_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  beat_if.sink        beats,
  input  qptr_arr_t   heads,
  output qptr_arr_t   tails,
  output logic        wr_en,
  output mem_addr_t   wr_addr,
  output word_t       wr_data,
  output logic [15:0] drop_count
);

  // Highest occupancy that still leaves room for a full packet
  localparam int ADMIT_MAX = (1 << `REPLAY_SLOT_W) - `REPLAY_MAX_PKT;

  wr_state_e state;
  wr_state_e state_next;
  qid_t      cur_q;
  // Write pointers, ahead of the published tails while a write is in flight
  qptr_arr_t wptr;
  qptr_t     occupancy;
  logic      accept;
  logic      admit;

  // Occupancy of the queue named by the waiting beat
  assign occupancy = wptr[beats.qid] - heads[beats.qid];
  assign admit     = (occupancy <= qptr_t'(ADMIT_MAX));

  // No beat is taken during the decide cycle
  assign beats.ready = (state == WR_PKT) || (state == WR_DROP);
  assign accept      = beats.valid && beats.ready;

  always_comb begin
    state_next = state;
    case (state)
      WR_IDLE: begin
        if (beats.valid) begin
          state_next = admit ? WR_PKT : WR_DROP;
        end
      end
      WR_PKT, WR_DROP: begin
        if (accept && beats.last) begin
          state_next = WR_IDLE;
        end
      end
      default: begin
        state_next = WR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= WR_IDLE;
      cur_q      <= '0;
      wptr       <= '0;
      tails      <= '0;
      wr_en      <= 1'b0;
      drop_count <= '0;
    end else begin
      state <= state_next;
      wr_en <= accept && (state == WR_PKT);
      // Tails catch up on the edge that commits the write
      tails <= wptr;
      if (state == WR_IDLE && beats.valid) begin
        cur_q <= beats.qid;
      end
      if (accept && state == WR_PKT) begin
        wptr[cur_q] <= wptr[cur_q] + 1'b1;
      end
      // Whole packet dropped, counted on its last beat
      if (accept && state == WR_DROP && beats.last) begin
        drop_count <= drop_count + 16'd1;
      end
    end
  end

  // Write address and data, registered one cycle behind the accept
  always_ff @(posedge clk) begin
    if (accept) begin
      wr_addr <= {cur_q, wptr[cur_q][`REPLAY_SLOT_W-1:0]};
      wr_data <= beats.data;
    end
  end

endmodule

`default_nettype wire

/* ingress_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module ingress_fifo import replay_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  word_t  in_data,
  input  qid_t   in_qid,
  input  logic   in_last,
  input  logic   in_valid,
  output logic   in_ready,
  beat_if.source beats
);

  localparam int DEPTH = 4;

  word_t      data_q [DEPTH];
  qid_t       qid_q  [DEPTH];
  logic       last_q [DEPTH];
  logic [1:0] wr_ptr;
  logic [1:0] rd_ptr;
  logic [2:0] count;
  logic       init_done;
  logic       push;
  logic       pop;

  // Stays low for one cycle after reset
  assign in_ready = init_done && (count != 3'(DEPTH));
  assign push     = in_valid && in_ready;
  assign pop      = beats.valid && beats.ready;

  assign beats.valid = (count != 3'd0);
  assign beats.data  = data_q[rd_ptr];
  assign beats.qid   = qid_q[rd_ptr];
  assign beats.last  = last_q[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      init_done <= 1'b0;
    end else begin
      init_done <= 1'b1;
      if (push) begin
        wr_ptr <= wr_ptr + 2'd1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 2'd1;
      end
      if (push && !pop) begin
        count <= count + 3'd1;
      end else if (pop && !push) begin
        count <= count - 3'd1;
      end
    end
  end

  // Beat storage
  always_ff @(posedge clk) begin
    if (push) begin
      data_q[wr_ptr] <= in_data;
      qid_q[wr_ptr]  <= in_qid;
      last_q[wr_ptr] <= in_last;
    end
  end

endmodule

`default_nettype wire

/* beat_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface beat_if import replay_pkg::*; ();

  word_t data;
  qid_t  qid;
  // Marks the final beat of a packet
  logic  last;
  logic  valid;
  logic  ready;

  modport source (
    output data, qid, last, valid,
    input  ready
  );

  modport sink (
    input  data, qid, last, valid,
    output ready
  );

endinterface

`default_nettype wire

/* replay_pkg.sv */
`default_nettype none

`include "replay_settings.svh"

package replay_pkg;

  typedef logic [`REPLAY_QIDX_W-1:0] qid_t;

  // Slot offset plus a wrap bit so a full ring differs from an empty one
  typedef logic [`REPLAY_SLOT_W:0] qptr_t;
  typedef qptr_t [`REPLAY_NUM_Q-1:0] qptr_arr_t;

  typedef logic [`REPLAY_DATA_W-1:0] word_t;

  // Queue number above the slot offset
  typedef logic [`REPLAY_QIDX_W+`REPLAY_SLOT_W-1:0] mem_addr_t;

  typedef enum logic [1:0] {WR_IDLE, WR_PKT, WR_DROP} wr_state_e;
  typedef enum logic [1:0] {RD_PICK, RD_FETCH, RD_SEND} rd_state_e;

endpackage

`default_nettype wire

/* replay_settings.svh */
`ifndef REPLAY_SETTINGS_SVH
`define REPLAY_SETTINGS_SVH

// Number of replay queues, must equal 2 ** REPLAY_QIDX_W
`define REPLAY_NUM_Q 4

// Width of a queue number
`define REPLAY_QIDX_W 2

// Word offset inside one queue region, 64 words per queue
`define REPLAY_SLOT_W 6

`define REPLAY_DATA_W 32

// Free words a queue needs before a new packet is admitted
`define REPLAY_MAX_PKT 8

`endif
